//--- flist.f
+incdir+verilog
verilog/i2s_pkg.sv
verilog/i2s_rx.sv
verilog/i2s_chan_lane.sv
verilog/i2s_tx.sv
verilog/i2s_passthru_top.sv
test/tb_clk_gen.sv
test/tb_i2s_asserts.sv
test/tb_i2s_passthru.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the I2S pass-through testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_i2s_passthru -f flist.f

status=0
sim_out=$(./obj_dir/Vtb_i2s_passthru 2>&1) || status=$?
echo "$sim_out"

if grep -qx "Simulation finished: PASS" <<< "$sim_out"; then
  echo "run_sim: passed"
  exit 0
else
  echo "run_sim: failed (simulator status $status)"
  exit 1
fi

//--- test/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic CLK,
  output logic RESET
);

  localparam int RESET_CYCLES = 8;

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;  // 4 ns period.
  end

  initial begin
    RESET = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    RESET <= 1'b0;
  end

endmodule

`default_nettype wire

//--- test/tb_i2s_asserts.sv
`timescale 1ns/1ps
`default_nettype none
`include "i2s_defines.svh"

module tb_i2s_asserts
  import i2s_pkg::*;
(
  input wire logic                      CLK,
  input wire logic                      RESET,
  input wire i2s_clk_t                  clk_view,
  input wire i2s_sample_t               sample,
  input wire logic                      sample_valid,
  input wire logic [`I2S_WORD_BITS-1:0] results [`I2S_NUM_CHAN],
  input wire logic                      sdata_out
);

  // sticky per-check flags.
  logic valid_err = 1'b0;
  logic lane0_err = 1'b0;
  logic lane1_err = 1'b0;
  logic sdata_err = 1'b0;
  logic reset_err = 1'b0;
  logic error_seen;

  assign error_seen = valid_err | lane0_err | lane1_err | sdata_err | reset_err;

  // ==========================================================================
  // receiver and lanes
  // ==========================================================================
  valid_single: assert property (@(posedge CLK) disable iff (RESET)
    sample_valid |=> !sample_valid)
    else begin
      $error("sample_valid high two cycles in a row");
      valid_err = 1'b1;
    end

  lane0_update: assert property (@(posedge CLK) disable iff (RESET)
    (results[0] != $past(results[0])) |-> $past(sample_valid && (sample.chan == 1'b0)))
    else begin
      $error("left lane result changed without a left sample");
      lane0_err = 1'b1;
    end

  lane1_update: assert property (@(posedge CLK) disable iff (RESET)
    (results[1] != $past(results[1])) |-> $past(sample_valid && (sample.chan == 1'b1)))
    else begin
      $error("right lane result changed without a right sample");
      lane1_err = 1'b1;
    end

  // ==========================================================================
  // transmitter and reset values
  // ==========================================================================
  sdata_on_fall: assert property (@(posedge CLK) disable iff (RESET)
    (sdata_out != $past(sdata_out)) |-> $past(clk_view.bclk_fall))
    else begin
      $error("sdata_out changed away from a BCLK fall");
      sdata_err = 1'b1;
    end

  // values loaded by a reset edge are seen one cycle later.
  reset_quiet: assert property (@(posedge CLK)
    RESET |=> (!sample_valid && !clk_view.bclk_rise && !clk_view.bclk_fall &&
               !clk_view.slot_start && !sdata_out))
    else begin
      $error("control output not 0 during reset");
      reset_err = 1'b1;
    end

endmodule

bind i2s_passthru_top tb_i2s_asserts asserts0 (
  .CLK          (CLK),
  .RESET        (RESET),
  .clk_view     (clk_view),
  .sample       (sample),
  .sample_valid (sample_valid),
  .results      (results),
  .sdata_out    (sdata_out)
);

`default_nettype wire

//--- test/tb_i2s_passthru.sv
`timescale 1ns/1ps
`default_nettype none
`include "i2s_defines.svh"

module tb_i2s_passthru
  import i2s_pkg::*;
();

  localparam int W         = `I2S_WORD_BITS;
  localparam int BCLK_HALF = 8;  // CLK cycles per BCLK half period.
  localparam logic [W-1:0] SIGN = {1'b1, {(W-1){1'b0}}};

  logic      CLK;
  logic      RESET;
  logic      bclk_in  = 1'b0;
  logic      lrclk_in = 1'b0;
  logic      sdata_in = 1'b0;
  chan_cfg_t cfg [`I2S_NUM_CHAN] = '{'{OP_PASS, 4'd0}, '{OP_PASS, 4'd0}};
  logic      bclk_out;
  logic      lrclk_out;
  logic      sdata_out;

  logic [W-1:0] word_q [$];   // words in slot order, left first.
  chan_cfg_t    cfg_l_q [$];
  chan_cfg_t    cfg_r_q [$];
  logic [W-1:0] exp_l [$];
  logic [W-1:0] exp_r [$];
  string        name_l [$];
  string        name_r [$];
  logic [31:0]  lfsr_state = 32'h28cd6ee4;
  int           words_seen = 0;
  int           words_checked = 0;

  tb_clk_gen clk_gen0 (
    .CLK   (CLK),
    .RESET (RESET)
  );

  i2s_passthru_top dut0 (
    .CLK       (CLK),
    .RESET     (RESET),
    .bclk_in   (bclk_in),
    .lrclk_in  (lrclk_in),
    .sdata_in  (sdata_in),
    .cfg       (cfg),
    .bclk_out  (bclk_out),
    .lrclk_out (lrclk_out),
    .sdata_out (sdata_out)
  );

  // ==========================================================================
  // helpers
  // ==========================================================================
  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  // Galois form of x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h80200003;
    return s >> 1;
  endfunction

  task automatic draw_word(output logic [W-1:0] w);
    w = '0;
    for (int i = 0; i < W; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[W-2:0], lfsr_state[0]};  // one step per bit.
    end
  endtask

  function automatic chan_cfg_t make_cfg(input chan_op_e op, input int shift);
    chan_cfg_t c;
    c.op    = op;
    c.shift = shift[`I2S_SHIFT_BITS-1:0];
    return c;
  endfunction

  // expected lane output.
  function automatic logic [W-1:0] lane_model(input chan_cfg_t c, input logic [W-1:0] w);
    logic [W-1:0] v;
    v = w;
    case (c.op)
      OP_MUTE:   v = '0;
      OP_INVERT: v = (w == SIGN) ? ~SIGN : (~w + W'(1));
      OP_ATTEN: begin
        for (int i = 0; i < int'(c.shift); i++) begin
          v = {v[W-1], v[W-1:1]};  // sign bit refills the top.
        end
      end
      default:   v = w;
    endcase
    return v;
  endfunction

  task automatic add_frame(input string name, input chan_cfg_t cl, input chan_cfg_t cr,
                           input logic [W-1:0] wl, input logic [W-1:0] wr);
    word_q.push_back(wl);
    cfg_l_q.push_back(cl);
    cfg_r_q.push_back(cr);
    exp_l.push_back(lane_model(cl, wl));
    name_l.push_back(name);
    word_q.push_back(wr);
    cfg_l_q.push_back(cl);
    cfg_r_q.push_back(cr);
    exp_r.push_back(lane_model(cr, wr));
    name_r.push_back(name);
  endtask

  task automatic check_word(input logic chan, input logic [W-1:0] word);
    logic [W-1:0] expected;
    string        name;
    if (chan == 1'b0) begin
      if (exp_l.size() == 0) return;  // past the end of the test.
      expected = exp_l.pop_front();
      name     = name_l.pop_front();
    end else begin
      if (exp_r.size() == 0) return;
      expected = exp_r.pop_front();
      name     = name_r.pop_front();
    end
    words_checked++;
    assert (word == expected) else begin
      $display("[FAIL] %s (%s): expected %h, actual %h",
               name, chan ? "right" : "left", expected, word);
      abort_run();
    end
  endtask

  // ==========================================================================
  // I2S master, data one BCLK after each LRCLK change
  // ==========================================================================
  int phase  = 0;
  int fall_n = 0;

  always @(posedge CLK) begin : i2s_master
    int m;
    int w;
    if (RESET) begin
      phase    <= 0;
      fall_n   <= 0;
      bclk_in  <= 1'b0;
      lrclk_in <= 1'b0;
      sdata_in <= 1'b0;
    end else begin
      m = fall_n - 1;
      w = fall_n / W;
      phase <= (phase + 1) % (2 * BCLK_HALF);
      if (phase == BCLK_HALF - 1) begin
        bclk_in <= 1'b1;
      end
      if (phase == 2 * BCLK_HALF - 1) begin
        bclk_in  <= 1'b0;
        lrclk_in <= w[0];
        if (m >= 0 && m / W < word_q.size()) begin
          sdata_in <= word_q[m / W][W - 1 - (m % W)];
        end else begin
          sdata_in <= 1'b0;
        end
        // mid slot, far from any sample strobe.
        if (fall_n % W == W / 2 && w < cfg_l_q.size()) begin
          cfg[0] <= cfg_l_q[w];
          cfg[1] <= cfg_r_q[w];
        end
        fall_n <= fall_n + 1;
      end
    end
  end

  // ==========================================================================
  // output decoder
  // ==========================================================================
  logic         dec_bclk = 1'b0;
  logic         dec_lr   = 1'b0;
  logic [W-1:0] dec_word = '0;

  always @(negedge CLK) begin
    if (RESET) begin
      dec_bclk = 1'b0;
      dec_lr   = 1'b0;
      dec_word = '0;
    end else begin
      if (words_seen < 2) begin
        assert (sdata_out == 1'b0) else begin
          $display("[FAIL] after_reset: expected sdata_out 0, actual %b", sdata_out);
          abort_run();
        end
      end
      if (bclk_out && !dec_bclk) begin
        dec_word = {dec_word[W-2:0], sdata_out};
        if (lrclk_out != dec_lr) begin
          words_seen++;
          check_word(dec_lr, dec_word);  // slot ended one BCLK late.
        end
        dec_lr = lrclk_out;
      end
      dec_bclk = bclk_out;
    end
  end

  // ==========================================================================
  // test sequence
  // ==========================================================================
  initial begin
    logic [W-1:0] wl;
    logic [W-1:0] wr;
    int           shifts [3];
    int           total;
    int           limit;
    int           cycles;

    shifts = '{0, 1, 15};
    exp_l.push_back('0);
    name_l.push_back("after_reset");
    exp_r.push_back('0);
    name_r.push_back("after_reset");

    repeat (8) begin
      draw_word(wl);
      draw_word(wr);
      add_frame("pass_through", make_cfg(OP_PASS, 0), make_cfg(OP_PASS, 0), wl, wr);
    end

    // saturation corner first.
    draw_word(wl);
    add_frame("mute_invert", make_cfg(OP_MUTE, 0), make_cfg(OP_INVERT, 0), wl, SIGN);
    draw_word(wl);
    add_frame("mute_invert", make_cfg(OP_MUTE, 0), make_cfg(OP_INVERT, 0), wl, ~SIGN);
    repeat (3) begin
      draw_word(wl);
      draw_word(wr);
      add_frame("mute_invert", make_cfg(OP_MUTE, 0), make_cfg(OP_INVERT, 0), wl, wr);
    end

    for (int k = 0; k < 3; k++) begin
      draw_word(wl);
      draw_word(wr);
      add_frame("atten_shift", make_cfg(OP_ATTEN, shifts[k]), make_cfg(OP_ATTEN, shifts[k]),
                wl | SIGN, wr & ~SIGN);
      draw_word(wl);
      draw_word(wr);
      add_frame("atten_shift", make_cfg(OP_ATTEN, shifts[k]), make_cfg(OP_ATTEN, shifts[k]),
                wl & ~SIGN, wr | SIGN);
    end
    draw_word(wl);
    draw_word(wr);
    add_frame("atten_shift", make_cfg(OP_ATTEN, 1), make_cfg(OP_ATTEN, 15), wl | SIGN, wr | SIGN);

    // one lane steps through every op while the other stays on pass.
    for (int k = 0; k < 4; k++) begin
      draw_word(wl);
      draw_word(wr);
      add_frame("lane_independence", make_cfg(chan_op_e'(k), 3), make_cfg(OP_PASS, 0), wl, wr);
    end
    for (int k = 0; k < 4; k++) begin
      draw_word(wl);
      draw_word(wr);
      add_frame("lane_independence", make_cfg(OP_PASS, 0), make_cfg(chan_op_e'(k), 3), wl, wr);
    end

    total  = exp_l.size() + exp_r.size();
    limit  = (word_q.size() / 2 + 4) * 2 * W * 2 * BCLK_HALF + 256;
    cycles = 0;
    while (words_checked < total) begin
      @(posedge CLK);
      cycles++;
      if (dut0.asserts0.error_seen) begin
        $display("a bound assertion failed at cycle %0d", cycles);
        abort_run();
      end
      if (cycles > limit) begin
        $display("timeout: only %0d of %0d words decoded after %0d cycles",
                 words_checked, total, cycles);
        abort_run();
      end
    end

    if (dut0.asserts0.error_seen) begin
      $display("a bound assertion failed");
      abort_run();
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- verilog/i2s_chan_lane.sv
`timescale 1ns/1ps
`default_nettype none
`include "i2s_defines.svh"

module i2s_chan_lane
  import i2s_pkg::*;
#(
  parameter int LANE_ID = 0
) (
  input  wire logic                      CLK,
  input  wire logic                      RESET,
  input  wire i2s_sample_t               sample,
  input  wire logic                      sample_valid,
  input  wire chan_cfg_t                 cfg,
  output logic [`I2S_WORD_BITS-1:0]      result
);

  localparam int         W        = `I2S_WORD_BITS;
  localparam logic       CHAN_SEL = 1'(LANE_ID);
  localparam logic [W-1:0] MOST_NEG = {1'b1, {(W-1){1'b0}}};
  localparam logic [W-1:0] MOST_POS = {1'b0, {(W-1){1'b1}}};

  logic signed [W-1:0] word_s;
  logic        [W-1:0] next_result;
  logic                hit;

  assign word_s = sample.data;
  assign hit    = sample_valid && (sample.chan == CHAN_SEL);

  // ========================================================================
  // channel operation
  // ========================================================================
  always_comb begin
    case (cfg.op)
      OP_PASS: next_result = sample.data;
      OP_MUTE: next_result = '0;
      OP_INVERT: begin
        // negation would overflow on the most negative word.
        if (sample.data == MOST_NEG) begin
          next_result = MOST_POS;
        end else begin
          next_result = -sample.data;
        end
      end
      OP_ATTEN: next_result = word_s >>> cfg.shift;  // sign kept.
      default:  next_result = sample.data;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      result <= '0;
    end else if (hit) begin
      result <= next_result;  // otherwise held for the transmitter.
    end
  end

endmodule

`default_nettype wire

//--- verilog/i2s_defines.svh
`ifndef I2S_DEFINES_SVH
`define I2S_DEFINES_SVH

// ==========================================================================
// link geometry
// ==========================================================================

// bits per audio word, also BCLK periods per slot.
`define I2S_WORD_BITS 32

// channel lanes, 0 is left (LRCLK low) and 1 is right.
`define I2S_NUM_CHAN 2

// ==========================================================================
// channel operation
// ==========================================================================

`define I2S_SHIFT_BITS 4 // attenuation shift field.

`endif

//--- verilog/i2s_passthru_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "i2s_defines.svh"

module i2s_passthru_top
  import i2s_pkg::*;
(
  input  wire logic      CLK,
  input  wire logic      RESET,
  input  wire logic      bclk_in,
  input  wire logic      lrclk_in,
  input  wire logic      sdata_in,
  input  wire chan_cfg_t cfg [`I2S_NUM_CHAN],
  output logic           bclk_out,
  output logic           lrclk_out,
  output logic           sdata_out
);

  i2s_clk_t    clk_view;
  i2s_sample_t sample;
  logic        sample_valid;
  logic [`I2S_WORD_BITS-1:0] results [`I2S_NUM_CHAN];

  // ========================================================================
  // receiver, lanes, transmitter
  // ========================================================================
  i2s_rx rx0 (
    .CLK          (CLK),
    .RESET        (RESET),
    .bclk_in      (bclk_in),
    .lrclk_in     (lrclk_in),
    .sdata_in     (sdata_in),
    .clk_view     (clk_view),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

  // every lane sees every sample and picks its own channel.
  for (genvar i = 0; i < `I2S_NUM_CHAN; i++) begin : lane_gen
    i2s_chan_lane #(
      .LANE_ID (i)
    ) lane0 (
      .CLK          (CLK),
      .RESET        (RESET),
      .sample       (sample),
      .sample_valid (sample_valid),
      .cfg          (cfg[i]),
      .result       (results[i])
    );
  end

  i2s_tx tx0 (
    .CLK       (CLK),
    .RESET     (RESET),
    .clk_view  (clk_view),
    .results   (results),
    .bclk_out  (bclk_out),
    .lrclk_out (lrclk_out),
    .sdata_out (sdata_out)
  );

endmodule

`default_nettype wire

//--- verilog/i2s_pkg.sv
`default_nettype none
`include "i2s_defines.svh"

package i2s_pkg;

  // per channel operation applied by a lane.
  typedef enum logic [1:0] {
    OP_PASS   = 2'd0,
    OP_MUTE   = 2'd1,
    OP_INVERT = 2'd2,
    OP_ATTEN  = 2'd3
  } chan_op_e;

  // lane configuration, held static by the user.
  typedef struct packed {
    chan_op_e                    op;
    logic [`I2S_SHIFT_BITS-1:0]  shift;  // arithmetic right shift for OP_ATTEN.
  } chan_cfg_t;

  // one received word and the slot it came from.
  typedef struct packed {
    logic [`I2S_WORD_BITS-1:0]   data;
    logic                        chan;   // LRCLK level of the slot.
  } i2s_sample_t;

  // ========================================================================
  // bit clock and word clock as seen from CLK
  // ========================================================================
  typedef struct packed {
    logic bclk;        // synchronized level.
    logic lrclk;       // synchronized level.
    logic bclk_rise;   // one CLK strobe.
    logic bclk_fall;   // one CLK strobe.
    logic slot_start;  // BCLK rise that sees an LRCLK change.
  } i2s_clk_t;

endpackage

`default_nettype wire

//--- verilog/i2s_rx.sv
`timescale 1ns/1ps
`default_nettype none
`include "i2s_defines.svh"

module i2s_rx
  import i2s_pkg::*;
(
  input  wire logic   CLK,
  input  wire logic   RESET,
  input  wire logic   bclk_in,
  input  wire logic   lrclk_in,
  input  wire logic   sdata_in,
  output i2s_clk_t    clk_view,
  output i2s_sample_t sample,
  output logic        sample_valid
);

  localparam int W = `I2S_WORD_BITS;

  // ========================================================================
  // pin synchronizers
  // ========================================================================
  logic [1:0] bclk_sync;
  logic [1:0] lrclk_sync;
  logic [1:0] sdata_sync;

  always_ff @(posedge CLK) begin
    bclk_sync  <= {bclk_sync[0], bclk_in};
    lrclk_sync <= {lrclk_sync[0], lrclk_in};
    sdata_sync <= {sdata_sync[0], sdata_in};
  end

  // ========================================================================
  // edge detection and clock view
  // ========================================================================
  logic bclk_q;
  logic lrclk_q;
  logic sdata_q;
  logic rise_q;
  logic fall_q;
  logic slot_q;
  logic lr_last;       // LRCLK level seen at the previous BCLK rise.
  logic edge_rise;
  logic edge_fall;
  logic lr_change;

  assign edge_rise = bclk_sync[1] & ~bclk_q;
  assign edge_fall = ~bclk_sync[1] & bclk_q;
  assign lr_change = (lrclk_sync[1] != lr_last);

  always_ff @(posedge CLK) begin
    if (RESET) begin
      bclk_q  <= 1'b0;
      lrclk_q <= 1'b0;
      rise_q  <= 1'b0;
      fall_q  <= 1'b0;
      slot_q  <= 1'b0;
      lr_last <= 1'b0;
    end else begin
      bclk_q  <= bclk_sync[1];
      lrclk_q <= lrclk_sync[1];
      rise_q  <= edge_rise;
      fall_q  <= edge_fall;
      slot_q  <= edge_rise & lr_change;
      if (edge_rise) begin
        lr_last <= lrclk_sync[1];  // only updated on rises.
      end
    end
  end

  // data bit lines up with the strobes.
  always_ff @(posedge CLK) begin
    sdata_q <= sdata_sync[1];
  end

  assign clk_view = '{
    bclk:       bclk_q,
    lrclk:      lrclk_q,
    bclk_rise:  rise_q,
    bclk_fall:  fall_q,
    slot_start: slot_q
  };

  // ========================================================================
  // word assembly
  // ========================================================================
  logic [W-1:0] word_reg;
  logic [W-1:0] word_next;

  assign word_next = {word_reg[W-2:0], sdata_q};

  always_ff @(posedge CLK) begin
    if (RESET) begin
      word_reg     <= '0;
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= slot_q;
      if (rise_q) begin
        word_reg <= word_next;
      end
    end
  end

  // the bit taken on a slot start is the LSB of the word that just ended.
  always_ff @(posedge CLK) begin
    if (slot_q) begin
      sample.data <= word_next;
      sample.chan <= ~lrclk_q;  // level before the change.
    end
  end

endmodule

`default_nettype wire

//--- verilog/i2s_tx.sv
`timescale 1ns/1ps
`default_nettype none
`include "i2s_defines.svh"

module i2s_tx
  import i2s_pkg::*;
(
  input  wire logic                   CLK,
  input  wire logic                   RESET,
  input  wire i2s_clk_t               clk_view,
  input  wire logic [`I2S_WORD_BITS-1:0] results [`I2S_NUM_CHAN],
  output logic                        bclk_out,
  output logic                        lrclk_out,
  output logic                        sdata_out
);

  localparam int W        = `I2S_WORD_BITS;
  localparam int CNT_BITS = $clog2(W) + 1;

  logic                pending;    // load armed for the next fall.
  logic                slot_chan;  // LRCLK level of the new slot.
  logic [W-1:0]        shreg;
  logic [CNT_BITS-1:0] bit_cnt;
  logic                sdata_q;

  // ========================================================================
  // slot control and bit counter
  // ========================================================================
  always_ff @(posedge CLK) begin
    if (RESET) begin
      pending   <= 1'b0;
      slot_chan <= 1'b0;
      bit_cnt   <= CNT_BITS'(W);  // idle, drive 0.
      sdata_q   <= 1'b0;
    end else begin
      if (clk_view.slot_start) begin
        pending   <= 1'b1;
        slot_chan <= clk_view.lrclk;
      end else if (clk_view.bclk_fall) begin
        pending <= 1'b0;
      end

      if (clk_view.bclk_fall) begin
        if (pending) begin
          sdata_q <= results[slot_chan][W-1];  // MSB one BCLK after LRCLK.
          bit_cnt <= CNT_BITS'(1);
        end else if (bit_cnt != CNT_BITS'(W)) begin
          sdata_q <= shreg[W-1];
          bit_cnt <= bit_cnt + 1'b1;
        end else begin
          sdata_q <= 1'b0;  // past the end of the word.
        end
      end
    end
  end

  // ========================================================================
  // output shift register
  // ========================================================================
  always_ff @(posedge CLK) begin
    if (clk_view.bclk_fall) begin
      if (pending) begin
        shreg <= {results[slot_chan][W-2:0], 1'b0};
      end else begin
        shreg <= {shreg[W-2:0], 1'b0};
      end
    end
  end

  // clocks are forwarded as seen through the synchronizers.
  assign bclk_out  = clk_view.bclk;
  assign lrclk_out = clk_view.lrclk;
  assign sdata_out = sdata_q;

endmodule

`default_nettype wire
